//--- filelist.f
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_crtc_timing.sv
hdl/vga_cfg_regs.sv
hdl/vga_plane_mem.sv
hdl/vga_planar_fetch.sv
hdl/vga_planar_top.sv
sim/vga_planar_asserts.sv
sim/vga_planar_tb.sv

//--- hdl/vga_cfg_regs.sv
/*
  Host command decoder, no handshake, one command per clk
  Config takes effect on the next edge, memory writes leave registered
*/
`timescale 1ns/1ps

module vga_cfg_regs (
  input  logic                clk,
  input  logic                rst,
  input  vga_pkg::host_cmd_t  cmd_i,
  output vga_pkg::vga_cfg_t   cfg_o,
  output vga_pkg::mem_wr_t    mem_wr_o
);

  vga_pkg::mem_wr_t       wr_req_q;

  // Opcode decode, config register and write request
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // Display off, all planes masked
      cfg_o    <= '0;
      wr_req_q <= '0;
    end
    else
    begin
      // Payload follows every command
      wr_req_q <= '{wr_en: 1'b0, plane: cmd_i.plane, addr: cmd_i.addr, data: cmd_i.data};
      case (cmd_i.op)
        vga_pkg::HOST_CFG_WRITE:
        begin
          cfg_o.plane_enable <= cmd_i.data[3:0];
          cfg_o.dotclockdiv2 <= cmd_i.data[4];
          cfg_o.display_en   <= cmd_i.data[5];
        end
        vga_pkg::HOST_MEM_WRITE:
        begin
          // One-cycle write request
          wr_req_q.wr_en <= 1'b1;
        end
        default:
        begin
          // Nothing to do for a no-op
        end
      endcase
    end
  end

  assign mem_wr_o = wr_req_q;

endmodule

//--- hdl/vga_crtc_timing.sv
/*
  640x480 counters advancing one dot per enabled clk
  Counts, syncs and visible level are registered together and agree
*/
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_crtc_timing (
  input  logic               clk,
  input  logic               rst,
  input  logic               en_i,
  output vga_pkg::crtc_pos_t pos_o
);

  logic [9:0] h_next;
  logic [9:0] v_next;
  logic       h_wrap;

  // Levels decoded from a count pair
  function automatic vga_pkg::crtc_pos_t decode_pos(
    input logic [9:0] h,
    input logic [9:0] v
  );
    vga_pkg::crtc_pos_t p;
    p.h_count    = h;
    p.v_count    = v;
    // Active high syncs
    p.hsync      = (h >= 10'(`H_SYNC_START)) && (h < 10'(`H_SYNC_END));
    p.vsync      = (v >= 10'(`V_SYNC_START)) && (v < 10'(`V_SYNC_END));
    // Visible only inside both windows
    p.video_on_h = (h < 10'(`H_VISIBLE)) && (v < 10'(`V_VISIBLE));
    return p;
  endfunction

  // Next count pair
  always_comb
  begin
    h_wrap = (pos_o.h_count == 10'(`H_TOTAL - 1));
    h_next = h_wrap ? 10'd0 : pos_o.h_count + 10'd1;
    if (!h_wrap)
    begin
      v_next = pos_o.v_count;
    end
    else if (pos_o.v_count == 10'(`V_TOTAL - 1))
    begin
      // Frame wrap
      v_next = 10'd0;
    end
    else
    begin
      v_next = pos_o.v_count + 10'd1;
    end
  end

  // Counts and levels in one register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // Start of frame, levels decoded as for any other dot
      pos_o <= decode_pos(10'd0, 10'd0);
    end
    else if (en_i)
    begin
      pos_o <= decode_pos(h_next, v_next);
    end
  end

endmodule

//--- hdl/vga_macros.svh
/*
  640x480 display timing and video memory sizes, one dot per enabled clk
  READ_LATENCY must be 3 or more to match the memory output pipeline
*/
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Horizontal timing in dots
`define H_VISIBLE       640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

// Vertical timing in lines
`define V_VISIBLE       480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

// Words per scan line in normal mode, halved mode uses half
`define WORDS_PER_LINE  40

// Word address width within one plane
`define MEM_AW          15

// Cycles from read strobe to valid data
`define READ_LATENCY    3

`endif

//--- hdl/vga_pkg.sv
/*
  Shared types of the planar VGA path
  Sync levels are active high, attributes are raw 4-bit plane bits
*/
`include "vga_macros.svh"

package vga_pkg;

  // Host opcodes
  typedef enum logic [1:0] {
    HOST_NOP       = 2'd0,
    HOST_CFG_WRITE = 2'd1,
    HOST_MEM_WRITE = 2'd2
  } host_op_e;

  // Host command, data[5:0] carries the config on a config write
  typedef struct packed {
    host_op_e             op;
    logic [1:0]           plane;
    logic [`MEM_AW-1:0]   addr;
    logic [15:0]          data;
  } host_cmd_t;

  typedef struct packed {
    logic [3:0] plane_enable;
    logic       dotclockdiv2;
    logic       display_en;
  } vga_cfg_t;

  // Counts and levels of one dot, video_on_h covers both directions
  typedef struct packed {
    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       hsync;
    logic       vsync;
    logic       video_on_h;
  } crtc_pos_t;

  typedef struct packed {
    logic                 rd_stb;
    logic [1:0]           plane;
    logic [`MEM_AW-1:0]   addr;
  } mem_rd_t;

  typedef struct packed {
    logic                 wr_en;
    logic [1:0]           plane;
    logic [`MEM_AW-1:0]   addr;
    logic [15:0]          data;
  } mem_wr_t;

  typedef struct packed {
    logic [3:0] attr;
    logic       video_on;
    logic       hsync;
    logic       vsync;
  } pixel_t;

endpackage

//--- hdl/vga_planar_fetch.sv
/*
  Four-plane fetch and serialiser, one word per plane every 16 dots
  (32 when halved); attribute and syncs lag the counts by 10 cycles
  Expects read data exactly READ_LATENCY enabled cycles after a strobe
*/
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_planar_fetch (
  input  logic               clk,
  input  logic               rst,
  input  logic               en_i,
  input  vga_pkg::vga_cfg_t  cfg_i,
  input  vga_pkg::crtc_pos_t pos_i,
  output vga_pkg::mem_rd_t   rd_o,
  input  logic [15:0]        rd_data_i,
  output vga_pkg::pixel_t    pixel_o
);

  localparam int LAT    = `READ_LATENCY;
  // Start stage, four strobes, latency, plane 3 data stage
  localparam int STAGES = LAT + 5;
  // Sync delay equals the count-to-attribute latency
  localparam int DLY    = LAT + 7;
  localparam int AW     = `MEM_AW;
  localparam int WPL    = `WORDS_PER_LINE;

  logic [STAGES-1:0] pipe;
  logic              fetch_start;
  logic [9:0]        line_idx;
  logic [5:0]        line_words;
  logic [AW-1:0]     row_addr;
  logic [5:0]        col_addr;
  logic [AW-1:0]     word_offset;
  logic [1:0]        plane_addr0;
  logic [1:0]        plane_addr;
  logic [15:0]       plane0_tmp;
  logic [15:0]       plane1_tmp;
  logic [15:0]       plane2_tmp;
  logic [15:0]       plane0;
  logic [15:0]       plane1;
  logic [15:0]       plane2;
  logic [15:0]       plane3;
  logic [7:0]        mask_hi;
  logic [7:0]        mask_lo;
  logic [15:0]       bit_mask;
  logic [3:0]        plane_bits;
  logic [3:0]        attr_q;
  logic [DLY-1:0]    hsync_dly;
  logic [DLY-1:0]    vsync_dly;
  logic [DLY-1:0]    von_dly;

  // New word at every 16th dot, every 32nd when halved
  assign fetch_start = cfg_i.dotclockdiv2 ? (pos_i.h_count[4:0] == 5'd0)
                                          : (pos_i.h_count[3:0] == 4'd0);

  // Halved mode repeats each row pair with half the words
  assign line_idx   = cfg_i.dotclockdiv2 ? {1'b0, pos_i.v_count[9:1]} : pos_i.v_count;
  assign line_words = cfg_i.dotclockdiv2 ? 6'(WPL / 2) : 6'(WPL);

  // Strobes in stages 1 to 4, planes 0 to 3
  assign rd_o = '{rd_stb: |pipe[4:1], plane: plane_addr, addr: word_offset};

  // Bit 15 leads, so high byte walks first
  assign bit_mask = {mask_hi, mask_lo};

  assign plane_bits[0] = |(bit_mask & plane0);
  assign plane_bits[1] = |(bit_mask & plane1);
  assign plane_bits[2] = |(bit_mask & plane2);
  assign plane_bits[3] = |(bit_mask & plane3);

  assign pixel_o = '{attr: attr_q, video_on: von_dly[DLY-1],
                     hsync: hsync_dly[DLY-1], vsync: vsync_dly[DLY-1]};

  // Fetch stage shift register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pipe <= '0;
    end
    else if (en_i)
    begin
      pipe <= {pipe[STAGES-2:0], fetch_start};
    end
  end

  // Address arithmetic, two cycles behind the counts
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      row_addr    <= '0;
      col_addr    <= '0;
      word_offset <= '0;
      plane_addr0 <= 2'd0;
      plane_addr  <= 2'd0;
    end
    else if (en_i)
    begin
      row_addr    <= AW'(line_idx) * AW'(line_words);
      col_addr    <= cfg_i.dotclockdiv2 ? {1'b0, pos_i.h_count[9:5]} : pos_i.h_count[9:4];
      word_offset <= row_addr + AW'(col_addr);
      // Low count bits number the planes of the four strobes
      plane_addr0 <= pos_i.h_count[1:0];
      plane_addr  <= plane_addr0;
    end
  end

  // Plane data latches
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      // Planes 0 to 2 wait in temporaries
      if (pipe[LAT+1])
      begin
        plane0_tmp <= rd_data_i;
      end
      if (pipe[LAT+2])
      begin
        plane1_tmp <= rd_data_i;
      end
      if (pipe[LAT+3])
      begin
        plane2_tmp <= rd_data_i;
      end
      // All four move together with plane 3 arriving
      if (pipe[LAT+4])
      begin
        plane0 <= plane0_tmp;
        plane1 <= plane1_tmp;
        plane2 <= plane2_tmp;
        plane3 <= rd_data_i;
      end
    end
  end

  // Walking bit select
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mask_hi <= 8'h0;
      mask_lo <= 8'h0;
    end
    else if (en_i)
    begin
      // Halved mode holds each bit over an odd dot
      if (!(pos_i.h_count[0] && cfg_i.dotclockdiv2))
      begin
        mask_hi <= {pipe[LAT+4], mask_hi[7:1]};
        mask_lo <= {mask_hi[0], mask_lo[7:1]};
      end
    end
  end

  // Sync and visible delay lines
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hsync_dly <= '0;
      vsync_dly <= '0;
      von_dly   <= '0;
    end
    else if (en_i)
    begin
      hsync_dly <= {hsync_dly[DLY-2:0], pos_i.hsync};
      vsync_dly <= {vsync_dly[DLY-2:0], pos_i.vsync};
      von_dly   <= {von_dly[DLY-2:0], pos_i.video_on_h};
    end
  end

  // Attribute, blanked outside the visible area
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      attr_q <= 4'h0;
    end
    else if (en_i)
    begin
      // Stage DLY-2 lines up with the bit selected now
      attr_q <= von_dly[DLY-2] ? (cfg_i.plane_enable & plane_bits) : 4'h0;
    end
  end

endmodule

//--- hdl/vga_planar_top.sv
/*
  Planar VGA pixel path, no palette and no pixel clock divider
  display_en freezes timing, fetch and memory reads together
*/
`timescale 1ns/1ps

module vga_planar_top (
  input  logic               clk,
  input  logic               rst,
  input  vga_pkg::host_cmd_t host_cmd_i,
  output vga_pkg::pixel_t    pixel_o
);

  vga_pkg::vga_cfg_t  cfg;
  vga_pkg::crtc_pos_t pos;
  vga_pkg::mem_rd_t   mem_rd;
  vga_pkg::mem_wr_t   mem_wr;
  logic [15:0]        mem_rd_data;

  // Counters
  vga_crtc_timing u_timing (
    .clk   (clk),
    .rst   (rst),
    .en_i  (cfg.display_en),
    .pos_o (pos)
  );

  // Host decode and config
  vga_cfg_regs u_cfg (
    .clk      (clk),
    .rst      (rst),
    .cmd_i    (host_cmd_i),
    .cfg_o    (cfg),
    .mem_wr_o (mem_wr)
  );

  // Video memory
  vga_plane_mem u_mem (
    .clk       (clk),
    .rst       (rst),
    .en_i      (cfg.display_en),
    .rd_i      (mem_rd),
    .rd_data_o (mem_rd_data),
    .wr_i      (mem_wr)
  );

  // Plane fetch and serialiser
  vga_planar_fetch u_fetch (
    .clk       (clk),
    .rst       (rst),
    .en_i      (cfg.display_en),
    .cfg_i     (cfg),
    .pos_i     (pos),
    .rd_o      (mem_rd),
    .rd_data_i (mem_rd_data),
    .pixel_o   (pixel_o)
  );

endmodule

//--- hdl/vga_plane_mem.sv
/*
  Four planes of 16-bit video memory, unreset contents
  Read data valid READ_LATENCY enabled cycles after a strobe
  Host writes ignore the enable and never share the read port
*/
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_plane_mem (
  input  logic             clk,
  input  logic             rst,
  input  logic             en_i,
  input  vga_pkg::mem_rd_t rd_i,
  output logic [15:0]      rd_data_o,
  input  vga_pkg::mem_wr_t wr_i
);

  localparam int LAT = `READ_LATENCY;
  localparam int AW  = `MEM_AW;

  logic [15:0]  plane_mem [4][2**AW];
  logic [15:0]  rd_pipe [LAT];
  // Valid flag per data stage except the last
  logic [LAT-2:0] rd_vld;

  // Host write port
  always_ff @(posedge clk)
  begin
    if (wr_i.wr_en)
    begin
      plane_mem[wr_i.plane][wr_i.addr] <= wr_i.data;
    end
  end

  // Stage valid flags
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_vld <= '0;
    end
    else if (en_i)
    begin
      rd_vld <= {rd_vld[LAT-3:0], rd_i.rd_stb};
    end
  end

  // Registered read then output pipeline, several reads in flight
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (rd_i.rd_stb)
      begin
        rd_pipe[0] <= plane_mem[rd_i.plane][rd_i.addr];
      end
      for (int i = 1; i < LAT; i++)
      begin
        if (rd_vld[i-1])
        begin
          rd_pipe[i] <= rd_pipe[i-1];
        end
      end
    end
  end

  assign rd_data_o = rd_pipe[LAT-1];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the planar VGA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module vga_planar_tb \
  -f filelist.f \
  -o vga_planar_sim

./obj_dir/vga_planar_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- sim/vga_planar_asserts.sv
/*
  Read port checks bound to the memory, blanking check bound to the fetcher
  Assumes display_en stays high once the display has been switched on
*/
`timescale 1ns/1ps

module vga_planar_asserts #(
  parameter bit PIXEL_SIDE = 1'b0
) (
  input logic             clk,
  input logic             rst,
  input logic             en_i,
  input vga_pkg::mem_rd_t rd_i,
  input vga_pkg::pixel_t  pixel_i
);

  if (PIXEL_SIDE)
  begin : g_pixel
    a_blank_attr: assert property (@(posedge clk) disable iff (rst)
      !pixel_i.video_on |-> pixel_i.attr == 4'h0)
      else $error("attribute set during blanking");
  end
  else
  begin : g_read
    logic [2:0] stb_run;
    logic       stb_prev;
    logic [1:0] plane_prev;

    // Length of the current strobe burst
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        stb_run    <= 3'd0;
        stb_prev   <= 1'b0;
        plane_prev <= 2'd0;
      end
      else if (en_i)
      begin
        stb_run    <= rd_i.rd_stb ? ((stb_run == 3'd7) ? 3'd7 : stb_run + 3'd1) : 3'd0;
        stb_prev   <= rd_i.rd_stb;
        plane_prev <= rd_i.plane;
      end
    end

    a_stb_burst: assert property (@(posedge clk) disable iff (rst) stb_run <= 3'd4)
      else $error("read strobe high for more than four cycles");

    // Burst opens on plane 0
    a_plane_first: assert property (@(posedge clk) disable iff (rst)
      (en_i && rd_i.rd_stb && !stb_prev) |-> rd_i.plane == 2'd0)
      else $error("read burst does not start at plane 0");

    // Then counts up by one
    a_plane_step: assert property (@(posedge clk) disable iff (rst)
      (en_i && rd_i.rd_stb && stb_prev) |-> rd_i.plane == 2'(plane_prev + 2'd1))
      else $error("read planes out of order");

    a_stb_frozen: assert property (@(posedge clk) disable iff (rst)
      !en_i |-> !rd_i.rd_stb)
      else $error("read strobe while display disabled");
  end

endmodule

bind vga_planar_fetch vga_planar_asserts #(.PIXEL_SIDE(1'b1)) u_fetch_asserts (
  .clk     (clk),
  .rst     (rst),
  .en_i    (en_i),
  .rd_i    (rd_o),
  .pixel_i (pixel_o)
);

// Memory side sees no pixels
bind vga_plane_mem vga_planar_asserts #(.PIXEL_SIDE(1'b0)) u_mem_asserts (
  .clk     (clk),
  .rst     (rst),
  .en_i    (en_i),
  .rd_i    (rd_i),
  .pixel_i ('0)
);

//--- sim/vga_planar_golden.txt
# C data(hex) is a config write, W plane addr data (all hex) is a memory write
# E frame x y attr (decimal) is the expected attribute at one visible dot
# Normal mode word at y 5, x 32..47
W 0 0ca 8101
W 1 0ca 0180
W 2 0ca 8080
W 3 0ca 0001
# Last word of the last line
W 0 4aff 0001
W 1 4aff 0000
W 2 4aff 0000
W 3 4aff 0001
# Halved mode word for rows 10 and 11, x 64..95
W 0 066 c000
W 1 066 0001
W 2 066 8000
W 3 066 4000
# Display on, normal mode, all planes
C 2f
E 0 32 5 5
E 0 39 5 3
E 0 40 5 6
E 0 47 5 9
E 0 624 479 0
E 0 639 479 9
# Planes 0 and 2 only
C 25
E 1 32 5 5
E 1 39 5 1
E 1 40 5 4
E 1 47 5 1
E 1 639 479 1
# Halved mode, all planes
C 3f
E 2 64 10 5
E 2 65 10 5
E 2 66 10 9
E 2 67 10 9
E 2 95 10 2
E 2 64 11 5
E 2 66 11 9
# Write during display, seen on the next frame
W 0 066 0000
E 3 64 10 4
E 3 66 10 8

//--- sim/vga_planar_tb.sv
/*
  Drives host commands from the golden file and checks attributes at listed dots
  Screen position is rebuilt from the pixel output, display stays on once enabled
*/
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_planar_tb;

  localparam int TIMEOUT = 900000;

  logic               clk;
  logic               rst;
  vga_pkg::host_cmd_t host_cmd;
  vga_pkg::pixel_t    pixel;
  vga_pkg::pixel_t    prev_pixel;
  int                 frame_cnt;
  int                 x_pos;
  int                 y_pos;
  int                 line_cnt;
  int                 checks;
  int                 errors;
  bit                 aborted;

  vga_planar_top u_vga_planar_top (
    .clk        (clk),
    .rst        (rst),
    .host_cmd_i (host_cmd),
    .pixel_o    (pixel)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Output position tracker, sampled mid cycle
  always @(negedge clk)
  begin
    if (rst)
    begin
      frame_cnt  = 0;
      x_pos      = 0;
      y_pos      = -1;
      line_cnt   = 0;
      prev_pixel = '0;
    end
    else
    begin
      if (pixel.vsync && !prev_pixel.vsync)
      begin
        frame_cnt = frame_cnt + 1;
        y_pos     = -1;
      end
      if (pixel.hsync && !prev_pixel.hsync)
        line_cnt = line_cnt + 1;
      if (pixel.video_on && !prev_pixel.video_on)
      begin
        x_pos = 0;
        y_pos = y_pos + 1;
        // Lines counted from the top of each frame
        if (y_pos == 0)
          line_cnt = 0;
      end
      else
        x_pos = x_pos + 1;
      prev_pixel = pixel;
    end
  end

  task automatic send_cmd(input vga_pkg::host_op_e op, input logic [1:0] plane,
                          input logic [`MEM_AW-1:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    host_cmd = '{op: op, plane: plane, addr: addr, data: data};
    @(posedge clk);
    #1;
    host_cmd = '{op: vga_pkg::HOST_NOP, plane: 2'd0, addr: '0, data: 16'h0};
  endtask

  task automatic check_pixel(input string name, input vga_pkg::pixel_t got,
                             input vga_pkg::pixel_t exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("Fail at %0t ns: %s attr %h von %b hs %b vs %b, expected attr %h von %b hs %b vs %b",
               $time, name, got.attr, got.video_on, got.hsync, got.vsync,
               exp.attr, exp.video_on, exp.hsync, exp.vsync);
    end
    else
      $display("Pass %s", name);
  endtask

  // Only the sync bits count here
  task automatic check_cfg_sync(input string name, input vga_pkg::pixel_t got,
                                input vga_pkg::pixel_t exp);
    checks = checks + 1;
    if ({got.hsync, got.vsync} !== {exp.hsync, exp.vsync})
    begin
      errors = errors + 1;
      $display("Fail at %0t ns: %s hsync %b vsync %b, expected hsync %b vsync %b",
               $time, name, got.hsync, got.vsync, exp.hsync, exp.vsync);
    end
    else
      $display("Pass %s", name);
  endtask

  // Waits for a given output dot
  task automatic wait_dot(input int f, input int x, input int y);
    int n;
    for (n = 0; n < TIMEOUT; n++)
    begin
      @(negedge clk);
      #1;
      if (frame_cnt == f && x_pos == x && y_pos == y)
        break;
    end
    if (n == TIMEOUT)
    begin
      $display("Timed out waiting for frame %0d dot %0d line %0d", f, x, y);
      aborted = 1'b1;
    end
  endtask

  task automatic wait_line(input int lines);
    int n;
    for (n = 0; n < TIMEOUT; n++)
    begin
      @(negedge clk);
      #1;
      if (line_cnt == lines && pixel.hsync && !aborted)
        break;
    end
    if (n == TIMEOUT)
    begin
      $display("Timed out waiting for hsync number %0d of the frame", lines);
      aborted = 1'b1;
    end
  endtask

  // Own copy of the last level, the tracker has already moved on
  task automatic wait_blank();
    int n;
    bit was_on;
    was_on = pixel.video_on;
    for (n = 0; n < TIMEOUT; n++)
    begin
      @(negedge clk);
      #1;
      if (!pixel.video_on && was_on)
        break;
      was_on = pixel.video_on;
    end
    if (n == TIMEOUT)
    begin
      $display("Timed out waiting for the end of a visible line");
      aborted = 1'b1;
    end
  endtask

  task automatic run_golden();
    int    fd;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    string tok;
    fd = $fopen("sim/vga_planar_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the golden file");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd) && !aborted)
    begin
      if ($fgets(line, fd) == 0)
        continue;
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      void'($sscanf(line, "%s", tok));
      if (tok == "C")
      begin
        void'($sscanf(line, "%s %h", tok, a));
        send_cmd(vga_pkg::HOST_CFG_WRITE, 2'd0, '0, 16'(a));
      end
      else if (tok == "W")
      begin
        void'($sscanf(line, "%s %h %h %h", tok, a, b, c));
        send_cmd(vga_pkg::HOST_MEM_WRITE, 2'(a), `MEM_AW'(b), 16'(c));
      end
      else if (tok == "E")
      begin
        void'($sscanf(line, "%s %d %d %d %d", tok, a, b, c, d));
        wait_dot(a, b, c);
        if (!aborted)
          check_pixel($sformatf("frame %0d dot %0d line %0d", a, b, c), pixel,
                      '{attr: 4'(d), video_on: 1'b1, hsync: 1'b0, vsync: 1'b0});
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    vga_pkg::pixel_t first_bad;
    host_cmd = '{op: vga_pkg::HOST_NOP, plane: 2'd0, addr: '0, data: 16'h0};
    rst      = 1'b1;
    checks   = 0;
    errors   = 0;
    aborted  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Display off, output must stay quiet
    first_bad = '0;
    repeat (200)
    begin
      @(negedge clk);
      if (pixel !== '0 && first_bad == '0)
        first_bad = pixel;
    end
    check_pixel("idle output", first_bad, '0);

    run_golden();

    // Horizontal sync start at dot 656
    if (!aborted)
      wait_blank();
    if (!aborted)
    begin
      repeat (15) @(negedge clk);
      #1;
      check_cfg_sync("dot before hsync", pixel, '0);
      @(negedge clk);
      #1;
      check_cfg_sync("hsync start", pixel, '{attr: 4'h0, video_on: 1'b0,
                                           hsync: 1'b1, vsync: 1'b0});
    end

    // Vertical sync on line 490
    if (!aborted)
      wait_line(`V_SYNC_START);
    if (!aborted)
      check_cfg_sync("line before vsync", pixel, '{attr: 4'h0, video_on: 1'b0,
                                                 hsync: 1'b1, vsync: 1'b0});
    if (!aborted)
      wait_line(`V_SYNC_START + 1);
    if (!aborted)
      check_cfg_sync("vsync start", pixel, '{attr: 4'h0, video_on: 1'b0,
                                           hsync: 1'b1, vsync: 1'b1});

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !aborted)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
